//--- Bender.yml
package:
  name: cpu_subsystem

sources:
  - hw/cpuPkg.sv
  - hw/alu.sv
  - hw/registerFile.sv
  - hw/fetchUnit.sv
  - hw/controlUnit.sv
  - hw/memoryController.sv
  - hw/cpuTop.sv
  - target: simulation
    files:
      - bench/cpuTb_chk.sv
      - bench/cpuTb.sv

//--- bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	localparam int NumPrograms   = 4;
	localparam int BodyLen       = 180;
	localparam int ProgMax       = 512;
	localparam int RamWords      = 256;
	localparam int TimeoutCycles = 20000;

	logic              CLK_50MHZ;
	logic              reset;
	cpuPkg::instr_t    instruction;
	logic              outReady;
	cpuPkg::word_t     instAddr;
	logic              outValid;
	cpuPkg::outWrite_t outData;
	logic              halted;

	// Instruction memory played by the testbench
	cpuPkg::instr_t prog [ProgMax];
	int             progLen;

	// ISA model state
	cpuPkg::word_t  mReg [16];
	cpuPkg::word_t  mRam [RamWords];
	logic           mRamOk [RamWords];
	cpuPkg::flags_t mFlags;
	cpuPkg::word_t  mPc;
	logic           mHalted;

	cpuPkg::outWrite_t expOut [$];
	cpuPkg::word_t     expPc [$];
	cpuPkg::outWrite_t expWrite;
	cpuPkg::word_t     expAddr;

	logic          checking;
	cpuPkg::word_t lastAddr;
	int            cycles;
	int            errorCount;
	int            transfers;

	cpuTop u_cpuTop (
		.CLK_50MHZ(CLK_50MHZ), .reset(reset), .instruction(instruction), .outReady(outReady),
		.instAddr(instAddr), .outValid(outValid), .outData(outData), .halted(halted)
	);

	always #5 CLK_50MHZ = ~CLK_50MHZ;

	//////////////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////////////

	task automatic stopRun();
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errorCount++;
			stopRun();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Program building and ISA model
	//////////////////////////////////////////////////////////////////////

	function automatic cpuPkg::instr_t encode(input cpuPkg::opcode_e op,
			input cpuPkg::regSel_t dst, input logic [9:0] arg);
		return {op, dst, arg};
	endfunction

	// Register in arg[9:6], random filler below it
	function automatic logic [9:0] regArg(input cpuPkg::regSel_t src);
		logic [5:0] pad;
		pad = 6'($urandom);
		return {src, pad};
	endfunction

	// Past the program end every fetch is HALT
	function automatic cpuPkg::instr_t fetchWord(input cpuPkg::word_t addr);
		if (addr < progLen) begin
			return prog[addr];
		end
		return encode(cpuPkg::HALT, 4'd0, 10'd0);
	endfunction

	assign instruction = fetchWord(instAddr);

	task automatic modelStep(input cpuPkg::instr_t ins);
		cpuPkg::opcode_e op;
		cpuPkg::regSel_t dst;
		cpuPkg::regSel_t src;
		logic [9:0]      imm;
		cpuPkg::word_t   a;
		cpuPkg::word_t   b;
		cpuPkg::word_t   r;
		logic [16:0]     sum;
		logic            c;
		logic            taken;
		op  = cpuPkg::opcode_e'(ins[17:14]);
		dst = ins[13:10];
		src = ins[9:6];
		imm = ins[9:0];
		a   = mReg[dst];
		b   = (op == cpuPkg::ADDI) ? {6'd0, imm} : mReg[src];
		r   = '0;
		c   = 1'b0;
		expPc.push_back(mPc);
		if (op <= cpuPkg::MOV || op == cpuPkg::ADDI) begin
			case (op)
				cpuPkg::ADD, cpuPkg::ADDI: begin
					sum = {1'b0, a} + {1'b0, b};
					r   = sum[15:0];
					c   = sum[16];
				end
				cpuPkg::SUB: begin
					r = a - b;
					c = (a >= b);
				end
				cpuPkg::AND: r = a & b;
				cpuPkg::OR:  r = a | b;
				cpuPkg::XOR: r = a ^ b;
				cpuPkg::SHL: begin
					r = a << 1;
					c = a[15];
				end
				cpuPkg::SHR: begin
					r = a >> 1;
					c = a[0];
				end
				default: r = b;
			endcase
			mReg[dst]       = r;
			mFlags.zero     = (r == 16'd0);
			mFlags.carry    = c;
			mFlags.negative = r[15];
			mPc             = mPc + 16'd1;
		end else begin
			case (op)
				cpuPkg::LDI: mReg[dst] = {6'd0, imm};
				cpuPkg::LOAD: mReg[dst] = mRam[mReg[src] % RamWords];
				cpuPkg::STORE: begin
					if (a[15]) begin
						expOut.push_back({a[7:0], b});
					end else begin
						mRam[a % RamWords]   = b;
						mRamOk[a % RamWords] = 1'b1;
					end
				end
				cpuPkg::BR: begin
					case (dst[1:0])
						2'd1:    taken = mFlags.zero;
						2'd2:    taken = mFlags.carry;
						2'd3:    taken = mFlags.negative;
						default: taken = 1'b1;
					endcase
					if (taken) begin
						mPc = mPc + {{6{imm[9]}}, imm};
					end
				end
				default: mHalted = 1'b1;
			endcase
			if (!mHalted) begin
				mPc = mPc + 16'd1;
			end
		end
	endtask

	// Only instructions that the model reaches are executed
	task automatic emit(input cpuPkg::instr_t ins);
		prog[progLen] = ins;
		if (!mHalted && mPc == progLen) begin
			modelStep(ins);
		end
		progLen++;
	endtask

	function automatic int findLoadSrc();
		int start;
		int r;
		start = $urandom % 16;
		for (int i = 0; i < 16; i++) begin
			r = (start + i) % 16;
			if (mRamOk[mReg[r] % RamWords]) begin
				return r;
			end
		end
		return -1;
	endfunction

	function automatic int findStoreAddr(input logic toPort);
		int start;
		int r;
		start = $urandom % 16;
		for (int i = 0; i < 16; i++) begin
			r = (start + i) % 16;
			if (mReg[r][15] == toPort) begin
				return r;
			end
		end
		return -1;
	endfunction

	task automatic pickInstr(input int k, input logic live, output cpuPkg::instr_t ins);
		cpuPkg::opcode_e op;
		cpuPkg::regSel_t dst;
		cpuPkg::regSel_t src;
		logic [9:0]      imm;
		logic            toPort;
		int              pick;
		op  = cpuPkg::opcode_e'(4'($urandom % 13));
		dst = 4'($urandom);
		src = 4'($urandom);
		// Small immediates make RAM addresses collide more often
		imm = ($urandom % 2) ? 10'($urandom % 16) : 10'($urandom);
		// Keep branch targets inside the body
		if (op == cpuPkg::BR && k > BodyLen - 5) begin
			op = cpuPkg::ADDI;
		end
		case (op)
			cpuPkg::BR: ins = encode(op, dst, 10'($urandom % 4 + 1));
			cpuPkg::LDI, cpuPkg::ADDI: ins = encode(op, dst, imm);
			cpuPkg::LOAD: begin
				pick = live ? findLoadSrc() : int'(src);
				if (pick < 0) begin
					ins = encode(cpuPkg::LDI, dst, imm);
				end else begin
					ins = encode(op, dst, regArg(4'(pick)));
				end
			end
			cpuPkg::STORE: begin
				toPort = ($urandom % 3 == 0);
				pick   = findStoreAddr(toPort);
				if (pick < 0) begin
					pick = findStoreAddr(!toPort);
				end
				ins = encode(op, 4'(pick), regArg(src));
			end
			default: ins = encode(op, dst, regArg(src));
		endcase
	endtask

	task automatic genProgram();
		cpuPkg::instr_t ins;
		progLen = 0;
		for (int i = 0; i < 16; i++) begin
			mReg[i] = '0;
		end
		for (int i = 0; i < RamWords; i++) begin
			mRamOk[i] = 1'b0;
		end
		mFlags  = '0;
		mPc     = '0;
		mHalted = 1'b0;
		expOut.delete();
		expPc.delete();
		for (int k = 0; k < BodyLen; k++) begin
			pickInstr(k, mPc == k, ins);
			emit(ins);
		end
		// r15 becomes the port pointer 0x80F0
		emit(encode(cpuPkg::LDI, 4'd15, 10'h101));
		repeat (7) emit(encode(cpuPkg::SHL, 4'd15, regArg(4'd0)));
		emit(encode(cpuPkg::ADDI, 4'd15, 10'h070));
		for (int i = 0; i < 15; i++) begin
			emit(encode(cpuPkg::STORE, 4'd15, regArg(4'(i))));
			emit(encode(cpuPkg::ADDI, 4'd15, 10'd1));
		end
		emit(encode(cpuPkg::STORE, 4'd15, regArg(4'd15)));
		emit(encode(cpuPkg::HALT, 4'd0, 10'd0));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sink, monitor and timeout
	//////////////////////////////////////////////////////////////////////

	// Sink stalls about 30 percent of the cycles
	always @(posedge CLK_50MHZ) begin
		#1;
		outReady = ($urandom % 10) >= 3;
	end

	always @(negedge CLK_50MHZ) begin
		if (u_cpuTop.u_handshakeChecker.assertFailures != 0) begin
			$display("A bound assertion on the output handshake or halt failed at %0t ns",
				$time);
			stopRun();
		end
		if (checking) begin
			if (instAddr !== lastAddr) begin
				if (expPc.size() == 0) begin
					$display("Fetch address moved beyond the predicted sequence at %0t ns", $time);
					stopRun();
				end
				expAddr = expPc.pop_front();
				compare("instAddr", instAddr, expAddr);
				lastAddr = instAddr;
			end
			// Transfer happens on the next rising edge
			if (outValid && outReady) begin
				if (expOut.size() == 0) begin
					$display("Unexpected output write at %0t ns", $time);
					stopRun();
				end
				expWrite = expOut.pop_front();
				compare("outData.port", outData.port, expWrite.port);
				compare("outData.data", outData.data, expWrite.data);
				transfers++;
			end
		end
	end

	always @(posedge CLK_50MHZ) begin
		cycles = cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("Timeout after %0d cycles, the core never finished", cycles);
			stopRun();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	task automatic runProgram(input int p);
		checking = 1'b0;
		genProgram();
		@(posedge CLK_50MHZ);
		#1;
		reset = 1'b1;
		repeat (3) @(posedge CLK_50MHZ);
		#1;
		reset    = 1'b0;
		lastAddr = '1;
		transfers = 0;
		checking = 1'b1;
		@(negedge CLK_50MHZ);
		compare("outValid", outValid, 1'b0);
		compare("halted", halted, 1'b0);
		compare("instAddr", instAddr, 16'd0);
		while (!halted) begin
			@(negedge CLK_50MHZ);
		end
		compare("pending output writes", expOut.size(), 0);
		compare("pending fetches", expPc.size(), 0);
		// Stays quiet after HALT
		repeat (8) begin
			@(negedge CLK_50MHZ);
			compare("outValid", outValid, 1'b0);
			compare("halted", halted, 1'b1);
		end
		$display("Program %0d done, %0d output writes checked", p, transfers);
	endtask

	initial begin
		int seedValue;
		seedValue  = $urandom(32'he65b696b);
		CLK_50MHZ  = 1'b0;
		reset      = 1'b1;
		outReady   = 1'b0;
		checking   = 1'b0;
		progLen    = 0;
		cycles     = 0;
		errorCount = 0;
		transfers  = 0;
		lastAddr   = '1;
		for (int p = 0; p < NumPrograms; p++) begin
			runProgram(p);
		end
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- bench/cpuTb_chk.sv
`timescale 1ns/1ps

module handshakeChecker (
	input logic              CLK_50MHZ,
	input logic              reset,
	input logic              outValid,
	input logic              outReady,
	input cpuPkg::outWrite_t outData,
	input cpuPkg::word_t     instAddr,
	input logic              halted
);

	// Count of failed assertions
	int assertFailures = 0;

	// Held output word under back-pressure
	property outDataHeld;
		@(posedge CLK_50MHZ) disable iff (reset)
			(outValid && !outReady) |=> $stable(outData);
	endproperty

	// No new output once the core has stopped
	property quietAfterHalt;
		@(posedge CLK_50MHZ) disable iff (reset)
			halted |-> !$rose(outValid);
	endproperty

	// Core frozen while the sink stalls
	property fetchFrozen;
		@(posedge CLK_50MHZ) disable iff (reset)
			(outValid && !outReady) |=> $stable(instAddr);
	endproperty

	assert property (outDataHeld)
		else begin
			$error("outData changed while outValid was high and outReady low");
			assertFailures++;
		end
	assert property (quietAfterHalt)
		else begin
			$error("outValid rose while halted was high");
			assertFailures++;
		end
	assert property (fetchFrozen)
		else begin
			$error("instAddr moved while an output write was stalled");
			assertFailures++;
		end

endmodule

bind cpuTop handshakeChecker u_handshakeChecker (
	.CLK_50MHZ(CLK_50MHZ), .reset(reset), .outValid(outValid), .outReady(outReady),
	.outData(outData), .instAddr(instAddr), .halted(halted)
);

//--- build.f
hw/cpuPkg.sv
hw/alu.sv
hw/registerFile.sv
hw/fetchUnit.sv
hw/controlUnit.sv
hw/memoryController.sv
hw/cpuTop.sv
bench/cpuTb_chk.sv
bench/cpuTb.sv

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	input  cpuPkg::aluOp_e op,
	output cpuPkg::word_t  result,
	output cpuPkg::flags_t flags
);

	logic carryOut;

	always_comb begin
		result   = '0;
		carryOut = 1'b0;
		case (op)
			cpuPkg::ALU_ADD: begin
				{carryOut, result} = {1'b0, a} + {1'b0, b};
			end
			cpuPkg::ALU_SUB: begin
				// Carry set means no borrow
				result   = a - b;
				carryOut = (a >= b);
			end
			cpuPkg::ALU_AND: begin
				result = a & b;
			end
			cpuPkg::ALU_OR: begin
				result = a | b;
			end
			cpuPkg::ALU_XOR: begin
				result = a ^ b;
			end
			// Single-bit shifts of a, carry takes the bit shifted out
			cpuPkg::ALU_SHL: begin
				result   = {a[14:0], 1'b0};
				carryOut = a[15];
			end
			cpuPkg::ALU_SHR: begin
				result   = {1'b0, a[15:1]};
				carryOut = a[0];
			end
			cpuPkg::ALU_MOV: begin
				result = b;
			end
			default: begin
				result = a;
			end
		endcase
	end

	assign flags.zero     = (result == '0);
	assign flags.carry    = carryOut;
	assign flags.negative = result[15];

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic              CLK_50MHZ,
	input  logic              reset,
	input  cpuPkg::instr_t    instruction,
	input  cpuPkg::word_t     pc,
	input  logic              halted,
	input  logic              stall,
	input  cpuPkg::word_t     rdA,
	input  cpuPkg::word_t     rdB,
	input  cpuPkg::word_t     aluResult,
	input  cpuPkg::flags_t    aluFlags,
	input  cpuPkg::regWrite_t loadWb,
	output cpuPkg::aluOp_e    aluOp,
	output cpuPkg::word_t     opA,
	output cpuPkg::word_t     opB,
	output cpuPkg::regWrite_t regWr,
	output cpuPkg::regSel_t   srcA,
	output cpuPkg::regSel_t   srcB,
	output cpuPkg::memReq_t   memReq,
	output logic              branchTaken,
	output cpuPkg::word_t     branchTarget,
	output logic              haltReq
);

	cpuPkg::fields_t   fields;
	cpuPkg::word_t     immZero;
	cpuPkg::word_t     immSigned;
	cpuPkg::flags_t    flagReg;
	cpuPkg::condCode_e cond;
	cpuPkg::regWrite_t decodedWr;
	logic              isRegOp;
	logic              isAddi;
	logic              isLdi;
	logic              isLoad;
	logic              isStore;
	logic              condMet;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	assign fields    = cpuPkg::fields_t'(instruction);
	assign immZero   = cpuPkg::word_t'(fields.arg.imm);
	assign immSigned = {{6{fields.arg.imm[9]}}, fields.arg.imm};

	// Relies on ADD..MOV being the lowest opcodes
	assign isRegOp = (fields.opcode <= cpuPkg::MOV);
	assign isAddi  = (fields.opcode == cpuPkg::ADDI);
	assign isLdi   = (fields.opcode == cpuPkg::LDI);
	assign isLoad  = (fields.opcode == cpuPkg::LOAD);
	assign isStore = (fields.opcode == cpuPkg::STORE);

	always_comb begin
		case (fields.opcode)
			cpuPkg::SUB: aluOp = cpuPkg::ALU_SUB;
			cpuPkg::AND: aluOp = cpuPkg::ALU_AND;
			cpuPkg::OR:  aluOp = cpuPkg::ALU_OR;
			cpuPkg::XOR: aluOp = cpuPkg::ALU_XOR;
			cpuPkg::SHL: aluOp = cpuPkg::ALU_SHL;
			cpuPkg::SHR: aluOp = cpuPkg::ALU_SHR;
			cpuPkg::MOV: aluOp = cpuPkg::ALU_MOV;
			default:     aluOp = cpuPkg::ALU_ADD;
		endcase
	end

	// dst is both the first operand and the destination
	assign srcA = fields.dst;
	assign srcB = fields.arg.r.src;
	assign opA  = rdA;
	assign opB  = isAddi ? immZero : rdB;

	//////////////////////////////////////////////////////////////////////
	// Flags and branch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (reset) begin
			flagReg <= '0;
		end else if ((isRegOp || isAddi) && !halted && !stall) begin
			flagReg <= aluFlags;
		end
	end

	assign cond = cpuPkg::condCode_e'(fields.dst[1:0]);

	always_comb begin
		case (cond)
			cpuPkg::COND_ZERO:  condMet = flagReg.zero;
			cpuPkg::COND_CARRY: condMet = flagReg.carry;
			cpuPkg::COND_NEG:   condMet = flagReg.negative;
			default:            condMet = 1'b1;
		endcase
	end

	assign branchTaken  = (fields.opcode == cpuPkg::BR) && condMet && !halted;
	assign branchTarget = pc + 16'd1 + immSigned;
	assign haltReq      = (fields.opcode == cpuPkg::HALT) && !halted;

	//////////////////////////////////////////////////////////////////////
	// Memory request and writeback
	//////////////////////////////////////////////////////////////////////

	// STORE addresses through dst, LOAD through src
	assign memReq.valid = (isLoad || isStore) && !halted;
	assign memReq.write = isStore;
	assign memReq.addr  = isStore ? rdA : rdB;
	assign memReq.wdata = rdB;
	assign memReq.dst   = fields.dst;

	// LOAD and STORE decode no write of their own
	assign decodedWr.enable = (isRegOp || isAddi || isLdi) && !halted && !stall;
	assign decodedWr.dst    = fields.dst;
	assign decodedWr.data   = isLdi ? immZero : aluResult;

	// Pending load wins over the decoded write
	always_comb begin
		if (loadWb.enable) begin
			regWr = loadWb;
		end else begin
			regWr = decodedWr;
		end
	end

endmodule

//--- hw/cpuPkg.sv
package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [17:0] instr_t;
	typedef logic [3:0]  regSel_t;
	typedef logic [15:0] dataAddr_t;
	typedef logic [9:0]  imm_t;
	typedef logic [7:0]  portAddr_t;

	localparam int NumRegs = 16;

	// Address bit that selects the output port instead of the data RAM
	localparam int OutPortBit = 15;

	//////////////////////////////////////////////////////////////////////
	// Instruction set
	//////////////////////////////////////////////////////////////////////

	// Register operations come first, MOV is the last of them
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		AND   = 4'd2,
		OR    = 4'd3,
		XOR   = 4'd4,
		SHL   = 4'd5,
		SHR   = 4'd6,
		MOV   = 4'd7,
		LDI   = 4'd8,
		ADDI  = 4'd9,
		LOAD  = 4'd10,
		STORE = 4'd11,
		BR    = 4'd12,
		HALT  = 4'd13
	} opcode_e;

	typedef struct packed {
		regSel_t    src;
		logic [5:0] pad;
	} srcField_t;

	// Source register and immediate share the low ten bits
	typedef union packed {
		srcField_t r;
		imm_t      imm;
	} operand_t;

	typedef struct packed {
		opcode_e  opcode;
		regSel_t  dst;
		operand_t arg;
	} fields_t;

	// BR condition, taken from dst[1:0]
	typedef enum logic [1:0] {
		COND_ALWAYS = 2'd0,
		COND_ZERO   = 2'd1,
		COND_CARRY  = 2'd2,
		COND_NEG    = 2'd3
	} condCode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_MOV
	} aluOp_e;

	//////////////////////////////////////////////////////////////////////
	// Bundles and state machines
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
	} flags_t;

	typedef struct packed {
		logic      valid;
		logic      write;
		dataAddr_t addr;
		word_t     wdata;
		regSel_t   dst;
	} memReq_t;

	typedef struct packed {
		logic    enable;
		regSel_t dst;
		word_t   data;
	} regWrite_t;

	typedef struct packed {
		portAddr_t port;
		word_t     data;
	} outWrite_t;

	typedef enum logic {RUN, HALTED} fetchState_e;

	typedef enum logic [1:0] {IDLE, LOADWAIT, OUTWAIT} memState_e;

endpackage

//--- hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
	parameter int DataDepth = 256
) (
	input  logic              CLK_50MHZ,
	input  logic              reset,
	input  cpuPkg::instr_t    instruction,
	input  logic              outReady,
	output cpuPkg::word_t     instAddr,
	output logic              outValid,
	output cpuPkg::outWrite_t outData,
	output logic              halted
);

	// Fetch and control
	logic              stall;
	logic              branchTaken;
	cpuPkg::word_t     branchTarget;
	logic              haltReq;

	// Datapath
	cpuPkg::aluOp_e    aluOp;
	cpuPkg::word_t     opA;
	cpuPkg::word_t     opB;
	cpuPkg::word_t     aluResult;
	cpuPkg::flags_t    aluFlags;
	cpuPkg::regSel_t   srcA;
	cpuPkg::regSel_t   srcB;
	cpuPkg::word_t     rdA;
	cpuPkg::word_t     rdB;
	cpuPkg::regWrite_t regWr;

	// Memory side
	cpuPkg::memReq_t   memReq;
	cpuPkg::regWrite_t loadWb;

	fetchUnit u_fetchUnit (
		.CLK_50MHZ(CLK_50MHZ), .reset(reset), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .haltReq(haltReq),
		.instAddr(instAddr), .halted(halted)
	);

	controlUnit u_controlUnit (
		.CLK_50MHZ(CLK_50MHZ), .reset(reset), .instruction(instruction),
		.pc(instAddr), .halted(halted), .stall(stall), .rdA(rdA), .rdB(rdB),
		.aluResult(aluResult), .aluFlags(aluFlags), .loadWb(loadWb),
		.aluOp(aluOp), .opA(opA), .opB(opB), .regWr(regWr), .srcA(srcA), .srcB(srcB),
		.memReq(memReq), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.haltReq(haltReq)
	);

	alu u_alu (
		.a(opA), .b(opB), .op(aluOp), .result(aluResult), .flags(aluFlags)
	);

	registerFile u_registerFile (
		.CLK_50MHZ(CLK_50MHZ), .reset(reset), .wr(regWr),
		.selA(srcA), .selB(srcB), .rdA(rdA), .rdB(rdB)
	);

	memoryController #(
		.DataDepth(DataDepth)
	) u_memoryController (
		.CLK_50MHZ(CLK_50MHZ), .reset(reset), .req(memReq), .outReady(outReady),
		.loadWb(loadWb), .stall(stall), .outValid(outValid), .outData(outData)
	);

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
	input  logic          CLK_50MHZ,
	input  logic          reset,
	input  logic          stall,
	input  logic          branchTaken,
	input  cpuPkg::word_t branchTarget,
	input  logic          haltReq,
	output cpuPkg::word_t instAddr,
	output logic          halted
);

	cpuPkg::word_t       pc;
	cpuPkg::word_t       pcNext;
	cpuPkg::fetchState_e state;

	assign pcNext = branchTaken ? branchTarget : pc + 16'd1;

	always_ff @(posedge CLK_50MHZ) begin
		if (reset) begin
			pc    <= '0;
			state <= cpuPkg::RUN;
		end else begin
			case (state)
				cpuPkg::RUN: begin
					// HALT freezes the pc on its own address
					if (haltReq) begin
						state <= cpuPkg::HALTED;
					end else if (!stall) begin
						pc <= pcNext;
					end
				end
				// Sticky until reset
				cpuPkg::HALTED: state <= cpuPkg::HALTED;
				default: state <= cpuPkg::RUN;
			endcase
		end
	end

	assign instAddr = pc;
	assign halted   = (state == cpuPkg::HALTED);

endmodule

//--- hw/memoryController.sv
`timescale 1ns/1ps

module memoryController #(
	parameter int DataDepth = 256
) (
	input  logic              CLK_50MHZ,
	input  logic              reset,
	input  cpuPkg::memReq_t   req,
	input  logic              outReady,
	output cpuPkg::regWrite_t loadWb,
	output logic              stall,
	output logic              outValid,
	output cpuPkg::outWrite_t outData
);

	localparam int IndexBits = $clog2(DataDepth);

	cpuPkg::word_t        ram [DataDepth];
	cpuPkg::memState_e    state;
	logic [IndexBits-1:0] ramIndex;
	cpuPkg::regSel_t      loadDst;
	cpuPkg::word_t        loadData;
	logic                 toPort;
	logic                 accept;

	assign ramIndex = IndexBits'(req.addr % DataDepth);
	assign toPort   = req.addr[cpuPkg::OutPortBit];

	// Requests are only taken in IDLE, the held instruction repeats them
	assign accept = (state == cpuPkg::IDLE) && req.valid;

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50MHZ) begin
		if (reset) begin
			state <= cpuPkg::IDLE;
		end else begin
			case (state)
				cpuPkg::IDLE: begin
					if (accept && !req.write) begin
						state <= cpuPkg::LOADWAIT;
					end else if (accept && toPort) begin
						state <= cpuPkg::OUTWAIT;
					end
				end
				cpuPkg::LOADWAIT: state <= cpuPkg::IDLE;
				cpuPkg::OUTWAIT: begin
					if (outReady) begin
						state <= cpuPkg::IDLE;
					end
				end
				default: state <= cpuPkg::IDLE;
			endcase
		end
	end

	always_comb begin
		case (state)
			cpuPkg::IDLE:    stall = accept && (!req.write || toPort);
			cpuPkg::OUTWAIT: stall = !outReady;
			default:         stall = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Data RAM, load pipeline register and output holding register
	//////////////////////////////////////////////////////////////////////

	// Loads always read the RAM, bit 15 only steers stores
	always_ff @(posedge CLK_50MHZ) begin
		if (accept && req.write && !toPort) begin
			ram[ramIndex] <= req.wdata;
		end
		if (accept && !req.write) begin
			loadData <= ram[ramIndex];
			loadDst  <= req.dst;
		end
		if (accept && req.write && toPort) begin
			outData.port <= req.addr[7:0];
			outData.data <= req.wdata;
		end
	end

	assign loadWb.enable = (state == cpuPkg::LOADWAIT);
	assign loadWb.dst    = loadDst;
	assign loadWb.data   = loadData;
	assign outValid      = (state == cpuPkg::OUTWAIT);

endmodule

//--- hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic              CLK_50MHZ,
	input  logic              reset,
	input  cpuPkg::regWrite_t wr,
	input  cpuPkg::regSel_t   selA,
	input  cpuPkg::regSel_t   selB,
	output cpuPkg::word_t     rdA,
	output cpuPkg::word_t     rdB
);

	cpuPkg::word_t regs [cpuPkg::NumRegs];

	// One write port, written on the retiring edge
	always_ff @(posedge CLK_50MHZ) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.enable) begin
			regs[wr.dst] <= wr.data;
		end
	end

	// Asynchronous reads
	assign rdA = regs[selA];
	assign rdB = regs[selB];

endmodule
